// ==== src/iq_pkg.sv ====
`default_nettype none

package iq_pkg;

    localparam int IQ_DEPTH      = 8;  // number of queue slots.
    localparam int PREG_WIDTH    = 6;  // physical register tag width.
    localparam int ROB_IDX_WIDTH = 5;  // rob index width, wrap flag not included.

    // physical register tag as seen by rename and writeback.
    typedef logic [PREG_WIDTH-1:0] preg_t;

    // rob position; the wrap flag travels beside it as a separate bit.
    typedef logic [ROB_IDX_WIDTH-1:0] rob_idx_t;

    // one bit per slot, used for pointers and per-slot status.
    typedef logic [IQ_DEPTH-1:0] iq_oh_t;

    // alu operation carried with each instruction.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/iq_entry.sv ====
`default_nettype none

module iq_entry
    import iq_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  logic     write,              // load the enqueue payload into this slot.
    input  logic     issue,              // the slot leaves the queue this cycle.
    input  preg_t    enq_prs1,
    input  preg_t    enq_prs2,
    input  preg_t    enq_prd,
    input  logic     enq_src1_is_reg,
    input  logic     enq_src2_is_reg,
    input  logic     enq_src1_state,
    input  logic     enq_src2_state,
    input  alu_op_e  enq_alu_op,
    input  logic     enq_robidx_flag,
    input  rob_idx_t enq_robidx,
    input  logic     writeback0_valid,
    input  preg_t    writeback0_prd,
    input  logic     writeback1_valid,
    input  preg_t    writeback1_prd,
    input  logic     flush_valid,
    input  logic     flush_robidx_flag,
    input  rob_idx_t flush_robidx,
    output logic     valid,
    output logic     ready_to_go,
    output logic     killed,
    output preg_t    prs1,
    output preg_t    prs2,
    output preg_t    prd,
    output logic     src1_is_reg,
    output logic     src2_is_reg,
    output alu_op_e  alu_op,
    output logic     robidx_flag,
    output rob_idx_t robidx
);

    logic src1_state;
    logic src2_state;
    logic wake_src1;
    logic wake_src2;

    // a source wakes when either writeback port broadcasts its tag.
    assign wake_src1 = src1_is_reg &
                       ((writeback0_valid & (writeback0_prd == prs1)) |
                        (writeback1_valid & (writeback1_prd == prs1)));
    assign wake_src2 = src2_is_reg &
                       ((writeback0_valid & (writeback0_prd == prs2)) |
                        (writeback1_valid & (writeback1_prd == prs2)));

    // younger than the flush point when the wrap flags and the index order disagree.
    assign killed = flush_valid & valid &
                    ((flush_robidx_flag ^ robidx_flag) ^ (flush_robidx < robidx));

    // a non-register source needs no wakeup.
    assign ready_to_go = valid & (~src1_is_reg | src1_state) & (~src2_is_reg | src2_state);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid      <= 1'b0;
            src1_state <= 1'b0;
            src2_state <= 1'b0;
        end else if (killed || issue) begin
            valid <= 1'b0;
        end else if (write) begin
            valid      <= 1'b1;
            src1_state <= enq_src1_state;  // no bypass from a writeback in this cycle.
            src2_state <= enq_src2_state;
        end else begin
            if (wake_src1) src1_state <= 1'b1;
            if (wake_src2) src2_state <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            prs1        <= enq_prs1;
            prs2        <= enq_prs2;
            prd         <= enq_prd;
            src1_is_reg <= enq_src1_is_reg;
            src2_is_reg <= enq_src2_is_reg;
            alu_op      <= enq_alu_op;
            robidx_flag <= enq_robidx_flag;
            robidx      <= enq_robidx;
        end
    end

    // the pointer logic must only write into a free slot.
    write_to_free_slot: assert property (@(posedge clock) disable iff (!reset_n)
        write |-> !valid);

    // an issue is only granted to a slot that holds a ready instruction.
    issue_only_when_ready: assert property (@(posedge clock) disable iff (!reset_n)
        issue |-> (valid && ready_to_go));

endmodule

`default_nettype wire

// ==== src/iq_pointer_ctrl.sv ====
`default_nettype none

module iq_pointer_ctrl
    import iq_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  logic   enq_valid,
    input  logic   deq_ready,
    input  iq_oh_t slot_valid,
    input  iq_oh_t slot_ready,
    input  iq_oh_t slot_killed,
    output logic   enq_ready,
    output logic   deq_valid,
    output iq_oh_t write_oh,
    output iq_oh_t issue_oh
);

    iq_oh_t head_oh;
    iq_oh_t tail_oh;
    iq_oh_t tail_recover;
    logic   kill_any;
    logic   enq_fire;

    assign kill_any = |slot_killed;

    // the tail slot must be free, and nothing moves while a flush is killing entries.
    assign enq_ready = ~|(tail_oh & slot_valid) & ~kill_any;
    assign enq_fire  = enq_valid & enq_ready;
    assign write_oh  = enq_fire ? tail_oh : '0;

    // only the head may issue, which keeps instructions strictly in order.
    assign deq_valid = (|(head_oh & slot_valid & slot_ready)) & deq_ready & ~kill_any;
    assign issue_oh  = deq_valid ? head_oh : '0;

    // walk from the head towards the tail and stop at the oldest killed slot.
    always_comb begin
        iq_oh_t probe;
        logic   found;
        probe        = head_oh;
        found        = 1'b0;
        tail_recover = tail_oh;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!found && (|(probe & slot_killed))) begin
                tail_recover = probe;
                found        = 1'b1;
            end
            probe = {probe[IQ_DEPTH-2:0], probe[IQ_DEPTH-1]};
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head_oh <= iq_oh_t'(1);
        end else if (deq_valid) begin
            head_oh <= {head_oh[IQ_DEPTH-2:0], head_oh[IQ_DEPTH-1]};
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            tail_oh <= iq_oh_t'(1);
        end else if (kill_any) begin
            tail_oh <= tail_recover;  // killed entries are always the youngest ones.
        end else if (enq_fire) begin
            tail_oh <= {tail_oh[IQ_DEPTH-2:0], tail_oh[IQ_DEPTH-1]};
        end
    end

    // rotation and recovery must never lose or duplicate a pointer bit.
    pointers_one_hot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot(head_oh) && $onehot(tail_oh));

    // at most one slot is written and at most one slot issues per cycle.
    strobes_one_hot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0(write_oh) && $onehot0(issue_oh));

endmodule

`default_nettype wire

// ==== src/iq_issue_mux.sv ====
`default_nettype none

module iq_issue_mux
    import iq_pkg::*;
(
    input  iq_oh_t   issue_oh,
    input  preg_t    slot_prs1 [IQ_DEPTH],
    input  preg_t    slot_prs2 [IQ_DEPTH],
    input  preg_t    slot_prd [IQ_DEPTH],
    input  iq_oh_t   slot_src1_is_reg,
    input  iq_oh_t   slot_src2_is_reg,
    input  alu_op_e  slot_alu_op [IQ_DEPTH],
    input  iq_oh_t   slot_robidx_flag,
    input  rob_idx_t slot_robidx [IQ_DEPTH],
    output preg_t    deq_prs1,
    output preg_t    deq_prs2,
    output preg_t    deq_prd,
    output logic     deq_src1_is_reg,
    output logic     deq_src2_is_reg,
    output alu_op_e  deq_alu_op,
    output logic     deq_robidx_flag,
    output rob_idx_t deq_robidx
);

    // single bit fields reduce directly against the select vector.
    assign deq_src1_is_reg = |(issue_oh & slot_src1_is_reg);
    assign deq_src2_is_reg = |(issue_oh & slot_src2_is_reg);
    assign deq_robidx_flag = |(issue_oh & slot_robidx_flag);

    // and-or select; everything stays zero when no slot issues.
    always_comb begin
        logic [2:0] op_acc;
        deq_prs1   = '0;
        deq_prs2   = '0;
        deq_prd    = '0;
        deq_robidx = '0;
        op_acc     = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (issue_oh[i]) begin
                deq_prs1   = deq_prs1 | slot_prs1[i];
                deq_prs2   = deq_prs2 | slot_prs2[i];
                deq_prd    = deq_prd | slot_prd[i];
                deq_robidx = deq_robidx | slot_robidx[i];
                op_acc     = op_acc | slot_alu_op[i];
            end
        end
        deq_alu_op = alu_op_e'(op_acc);
    end

endmodule

`default_nettype wire

// ==== src/issue_queue.sv ====
`default_nettype none

module issue_queue
    import iq_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  logic     enq_valid,
    output logic     enq_ready,
    input  preg_t    enq_prs1,
    input  preg_t    enq_prs2,
    input  preg_t    enq_prd,
    input  logic     enq_src1_is_reg,
    input  logic     enq_src2_is_reg,
    input  logic     enq_src1_state,
    input  logic     enq_src2_state,
    input  alu_op_e  enq_alu_op,
    input  logic     enq_robidx_flag,
    input  rob_idx_t enq_robidx,
    input  logic     deq_ready,
    output logic     deq_valid,
    output preg_t    deq_prs1,
    output preg_t    deq_prs2,
    output preg_t    deq_prd,
    output logic     deq_src1_is_reg,
    output logic     deq_src2_is_reg,
    output alu_op_e  deq_alu_op,
    output logic     deq_robidx_flag,
    output rob_idx_t deq_robidx,
    input  logic     writeback0_valid,
    input  preg_t    writeback0_prd,
    input  logic     writeback1_valid,
    input  preg_t    writeback1_prd,
    input  logic     flush_valid,
    input  logic     flush_robidx_flag,
    input  rob_idx_t flush_robidx
);

    iq_oh_t   write_oh;
    iq_oh_t   issue_oh;
    iq_oh_t   slot_valid;
    iq_oh_t   slot_ready;
    iq_oh_t   slot_killed;
    iq_oh_t   slot_src1_is_reg;
    iq_oh_t   slot_src2_is_reg;
    iq_oh_t   slot_robidx_flag;
    preg_t    slot_prs1 [IQ_DEPTH];
    preg_t    slot_prs2 [IQ_DEPTH];
    preg_t    slot_prd [IQ_DEPTH];
    alu_op_e  slot_alu_op [IQ_DEPTH];
    rob_idx_t slot_robidx [IQ_DEPTH];

    iq_pointer_ctrl pointer_ctrl_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .enq_valid  (enq_valid),
        .deq_ready  (deq_ready),
        .slot_valid (slot_valid),
        .slot_ready (slot_ready),
        .slot_killed(slot_killed),
        .enq_ready  (enq_ready),
        .deq_valid  (deq_valid),
        .write_oh   (write_oh),
        .issue_oh   (issue_oh)
    );

    // every slot sees the same enqueue payload; write_oh picks the one that loads it.
    for (genvar i = 0; i < IQ_DEPTH; i++) begin : gen_slot
        iq_entry entry_inst (
            .clock            (clock),
            .reset_n          (reset_n),
            .write            (write_oh[i]),
            .issue            (issue_oh[i]),
            .enq_prs1         (enq_prs1),
            .enq_prs2         (enq_prs2),
            .enq_prd          (enq_prd),
            .enq_src1_is_reg  (enq_src1_is_reg),
            .enq_src2_is_reg  (enq_src2_is_reg),
            .enq_src1_state   (enq_src1_state),
            .enq_src2_state   (enq_src2_state),
            .enq_alu_op       (enq_alu_op),
            .enq_robidx_flag  (enq_robidx_flag),
            .enq_robidx       (enq_robidx),
            .writeback0_valid (writeback0_valid),
            .writeback0_prd   (writeback0_prd),
            .writeback1_valid (writeback1_valid),
            .writeback1_prd   (writeback1_prd),
            .flush_valid      (flush_valid),
            .flush_robidx_flag(flush_robidx_flag),
            .flush_robidx     (flush_robidx),
            .valid            (slot_valid[i]),
            .ready_to_go      (slot_ready[i]),
            .killed           (slot_killed[i]),
            .prs1             (slot_prs1[i]),
            .prs2             (slot_prs2[i]),
            .prd              (slot_prd[i]),
            .src1_is_reg      (slot_src1_is_reg[i]),
            .src2_is_reg      (slot_src2_is_reg[i]),
            .alu_op           (slot_alu_op[i]),
            .robidx_flag      (slot_robidx_flag[i]),
            .robidx           (slot_robidx[i])
        );
    end

    iq_issue_mux issue_mux_inst (
        .issue_oh        (issue_oh),
        .slot_prs1       (slot_prs1),
        .slot_prs2       (slot_prs2),
        .slot_prd        (slot_prd),
        .slot_src1_is_reg(slot_src1_is_reg),
        .slot_src2_is_reg(slot_src2_is_reg),
        .slot_alu_op     (slot_alu_op),
        .slot_robidx_flag(slot_robidx_flag),
        .slot_robidx     (slot_robidx),
        .deq_prs1        (deq_prs1),
        .deq_prs2        (deq_prs2),
        .deq_prd         (deq_prd),
        .deq_src1_is_reg (deq_src1_is_reg),
        .deq_src2_is_reg (deq_src2_is_reg),
        .deq_alu_op      (deq_alu_op),
        .deq_robidx_flag (deq_robidx_flag),
        .deq_robidx      (deq_robidx)
    );

endmodule

`default_nettype wire

// ==== verif/iq_model.svh ====
`ifndef IQ_MODEL_SVH
`define IQ_MODEL_SVH

// the reference queue keeps the oldest instruction at index 0.
typedef struct packed {
    preg_t    prs1;
    preg_t    prs2;
    preg_t    prd;
    logic     is_reg1;
    logic     is_reg2;
    logic     st1;
    logic     st2;
    alu_op_e  op;
    logic     flag;
    rob_idx_t idx;
} ref_entry_t;

ref_entry_t ref_queue[$];
int         next_rob;  // bit ROB_IDX_WIDTH holds the wrap flag.

function automatic logic is_killed(ref_entry_t e);
    return flush_valid && ((flush_robidx_flag ^ e.flag) ^ (flush_robidx < e.idx));
endfunction

function automatic logic kill_pending();
    foreach (ref_queue[i]) begin
        if (is_killed(ref_queue[i])) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic logic writeback_hits(preg_t tag);
    return (writeback0_valid && writeback0_prd == tag) ||
           (writeback1_valid && writeback1_prd == tag);
endfunction

function automatic logic enq_allowed();
    return (ref_queue.size() < IQ_DEPTH) && !kill_pending();
endfunction

// only the oldest entry may issue, and only with both sources ready.
function automatic logic issue_allowed();
    if (ref_queue.size() == 0 || kill_pending() || !deq_ready) begin
        return 1'b0;
    end
    return (!ref_queue[0].is_reg1 || ref_queue[0].st1) &&
           (!ref_queue[0].is_reg2 || ref_queue[0].st2);
endfunction

// moves the reference state across the coming clock edge.
task automatic advance_model();
    logic       killing;
    logic       issuing;
    logic       accepting;
    ref_entry_t e;
    killing   = kill_pending();
    issuing   = issue_allowed();
    accepting = enq_valid && enq_allowed();
    foreach (ref_queue[i]) begin
        if (ref_queue[i].is_reg1 && writeback_hits(ref_queue[i].prs1)) begin
            ref_queue[i].st1 = 1'b1;
        end
        if (ref_queue[i].is_reg2 && writeback_hits(ref_queue[i].prs2)) begin
            ref_queue[i].st2 = 1'b1;
        end
    end
    if (killing) begin
        for (int i = ref_queue.size() - 1; i >= 0; i--) begin
            if (is_killed(ref_queue[i])) begin
                ref_queue.delete(i);
            end
        end
        next_rob = int'({flush_robidx_flag, flush_robidx}) + 1;  // producer restarts here.
    end else begin
        if (issuing) begin
            void'(ref_queue.pop_front());
        end
        if (accepting) begin
            e = '{enq_prs1, enq_prs2, enq_prd, enq_src1_is_reg, enq_src2_is_reg,
                  enq_src1_state, enq_src2_state, enq_alu_op, enq_robidx_flag, enq_robidx};
            ref_queue.push_back(e);
            next_rob = next_rob + 1;
        end
    end
endtask

`endif

// ==== verif/issue_queue_tb.sv ====
`default_nettype none

module issue_queue_tb
    import iq_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES  = 3;
    localparam int FILL_CYCLES   = IQ_DEPTH + 4;
    localparam int RANDOM_CYCLES = 5000;
    localparam int TIMEOUT_NS    = (RESET_CYCLES + FILL_CYCLES + RANDOM_CYCLES) * 20 + 2000;

    logic     clock, reset_n;
    logic     enq_valid, enq_ready, deq_ready, deq_valid;
    preg_t    enq_prs1, enq_prs2, enq_prd, deq_prs1, deq_prs2, deq_prd;
    logic     enq_src1_is_reg, enq_src2_is_reg, enq_src1_state, enq_src2_state;
    logic     deq_src1_is_reg, deq_src2_is_reg, enq_robidx_flag, deq_robidx_flag;
    alu_op_e  enq_alu_op, deq_alu_op;
    rob_idx_t enq_robidx, deq_robidx, flush_robidx;
    logic     writeback0_valid, writeback1_valid, flush_valid, flush_robidx_flag;
    preg_t    writeback0_prd, writeback1_prd;
    integer   seed;
    int       accepted_count, issued_count, kill_cycles;

    `include "iq_model.svh"

    issue_queue issue_queue_inst (.*);

    always #10 clock = ~clock;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: actual 0x%h expected 0x%h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch on %s at %0t", name, $time);
        end
    endtask

    // mostly a tag that some queued source is waiting for.
    function automatic preg_t pick_wakeup_tag();
        int pick;
        if (ref_queue.size() == 0 || ($random(seed) & 3) == 0) begin
            return preg_t'($random(seed));
        end
        pick = int'($unsigned($random(seed)) % ref_queue.size());
        return (($random(seed) & 1) != 0) ? ref_queue[pick].prs1 : ref_queue[pick].prs2;
    endfunction

    task automatic drive_inputs(input logic enq_on, input logic random_mode);
        int pick;
        enq_valid        <= enq_on && (!random_mode || (($random(seed) & 3) != 0));
        enq_prs1         <= preg_t'($random(seed));
        enq_prs2         <= preg_t'($random(seed));
        enq_prd          <= preg_t'($random(seed));
        enq_src1_is_reg  <= ($random(seed) & 7) != 0;
        enq_src2_is_reg  <= ($random(seed) & 7) != 0;
        enq_src1_state   <= ($random(seed) & 3) == 0;  // most sources start out waiting.
        enq_src2_state   <= ($random(seed) & 3) == 0;
        enq_alu_op       <= alu_op_e'(3'($random(seed)));
        enq_robidx_flag  <= next_rob[ROB_IDX_WIDTH];
        enq_robidx       <= rob_idx_t'(next_rob);
        deq_ready        <= random_mode && (($random(seed) & 3) != 0);
        writeback0_valid <= random_mode && (($random(seed) & 1) != 0);
        writeback1_valid <= random_mode && (($random(seed) & 1) != 0);
        writeback0_prd   <= pick_wakeup_tag();
        writeback1_prd   <= pick_wakeup_tag();
        // a flush always names an instruction that is still in the queue.
        if (random_mode && ref_queue.size() > 0 && ($random(seed) & 15) == 0) begin
            pick = int'($unsigned($random(seed)) % ref_queue.size());
            flush_valid       <= 1'b1;
            flush_robidx_flag <= ref_queue[pick].flag;
            flush_robidx      <= ref_queue[pick].idx;
        end else begin
            flush_valid       <= 1'b0;
            flush_robidx_flag <= 1'b0;
            flush_robidx      <= '0;
        end
    endtask

    task automatic compare_outputs();
        ref_entry_t head;
        logic       issue_exp;
        issue_exp = issue_allowed();
        head      = '0;  // the dequeue payload reads zero without an issue.
        if (issue_exp) begin
            head = ref_queue[0];
        end
        check("enq_ready", 32'(enq_ready), 32'(enq_allowed()));
        check("deq_valid", 32'(deq_valid), 32'(issue_exp));
        check("deq payload {prs1,prs2,prd,src1_is_reg,src2_is_reg,alu_op,flag,robidx}",
              32'({deq_prs1, deq_prs2, deq_prd, deq_src1_is_reg, deq_src2_is_reg,
                   deq_alu_op, deq_robidx_flag, deq_robidx}),
              32'({head.prs1, head.prs2, head.prd, head.is_reg1, head.is_reg2,
                   head.op, head.flag, head.idx}));
    endtask

    // drive on the rising edge, check on the falling edge where outputs are settled.
    task automatic run_cycle(input logic random_mode);
        @(posedge clock);
        drive_inputs(1'b1, random_mode);
        @(negedge clock);
        compare_outputs();
        accepted_count += int'(enq_valid && enq_ready);
        issued_count   += int'(deq_valid);
        kill_cycles    += int'(kill_pending());
        advance_model();
    endtask

    initial begin
        seed           = 32'h2fee;
        clock          = 1'b0;
        reset_n        = 1'b0;
        accepted_count = 0;
        issued_count   = 0;
        kill_cycles    = 0;
        next_rob       = 0;
        drive_inputs(1'b0, 1'b0);
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check("enq_ready after reset", 32'(enq_ready), 32'd1);
        check("deq_valid after reset", 32'(deq_valid), 32'd0);
        repeat (FILL_CYCLES) run_cycle(1'b0);  // head held, so the queue must fill up.
        check("enqueues accepted while stalled", 32'(accepted_count), 32'(IQ_DEPTH));
        repeat (RANDOM_CYCLES) run_cycle(1'b1);
        check("issue seen in random run", 32'(issued_count != 0), 32'd1);
        check("kill seen in random run", 32'(kill_cycles != 0), 32'd1);
        $display("Test passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Simulation did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verif
src/iq_pkg.sv
src/iq_entry.sv
src/iq_pointer_ctrl.sv
src/iq_issue_mux.sv
src/issue_queue.sv
verif/issue_queue_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module issue_queue_tb \
        -f flist.f -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vissue_queue_tb 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" <<< "$sim_output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
